// ==== source/dbg_biu_pkg.sv ====
// Shared widths, word-size codes and Wishbone FSM encoding for the debug bus interface unit
// Imported by the capture, master and top-level modules

package dbg_biu_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // Data bus and debug data word
  localparam int DATA_W = 32;

  // Byte address
  localparam int ADDR_W = 32;

  // One select lane per byte of the data bus
  localparam int SEL_W = DATA_W / 8;

  //////////////////////////////////////////////////
  // Word-size codes from the debug controller
  //////////////////////////////////////////////////

  localparam int SIZE_W = 3;

  // Single byte access
  localparam logic [SIZE_W-1:0] SIZE_BYTE = SIZE_W'(1);

  // Halfword access, always halfword aligned
  localparam logic [SIZE_W-1:0] SIZE_HALF = SIZE_W'(2);

  // Full word access
  // Unknown codes are also run as a word access
  localparam logic [SIZE_W-1:0] SIZE_WORD = SIZE_W'(4);

  //////////////////////////////////////////////////
  // Wishbone master states
  //////////////////////////////////////////////////

  // Idle waits for a start pulse, xfer holds the cycle until ack or err
  typedef enum logic [0:0] {
    WB_IDLE = 1'b0,
    WB_XFER = 1'b1
  } wb_state_e;

endpackage

// ==== source/dbg_cmd_capture.sv ====
// TCK-side command stage of the debug bus unit
// Latches a strobed request, raises the start toggle and holds ready low until done

`timescale 1ns/10ps

module dbg_cmd_capture (
  input  logic                          tck_i,
  input  logic                          rst_i,
  // Request from the debug controller
  input  logic [dbg_biu_pkg::ADDR_W-1:0] addr_i,
  input  logic [dbg_biu_pkg::DATA_W-1:0] data_i,
  input  logic                          rd_wrn_i,
  input  logic [dbg_biu_pkg::SIZE_W-1:0] word_size_i,
  input  logic                          strobe_i,
  // Completion pulse, already in the TCK domain
  input  logic                          done_p_i,
  output logic                          rdy_o,
  output logic                          str_tgl_o,
  // Request held for the Wishbone side
  output logic [dbg_biu_pkg::SEL_W-1:0]  sel_o,
  output logic [dbg_biu_pkg::ADDR_W-1:0] adr_o,
  output logic [dbg_biu_pkg::DATA_W-1:0] wdat_o,
  output logic                          we_o
);

  import dbg_biu_pkg::*;

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  // Control state
  logic              rdy_q;
  logic              str_tgl_q;
  logic              we_q;

  // Request payload, held until the next acceptance
  logic [SEL_W-1:0]  sel_q;
  logic [ADDR_W-1:0] adr_q;
  logic [DATA_W-1:0] wdat_q;

  // Decoded lanes and lane-aligned write data
  logic [SEL_W-1:0]  sel_dec;
  logic [DATA_W-1:0] wdat_dec;

  // Short write data sits in the top bits of data_i
  logic [7:0]        top_byte;
  logic [15:0]       top_half;

  // Request taken on this edge
  logic              accept;

  assign accept   = strobe_i && rdy_q;
  assign top_byte = data_i[DATA_W-1 -: 8];
  assign top_half = data_i[DATA_W-1 -: 16];

  //////////////////////////////////////////////////
  // Byte-lane decode, big-endian
  //////////////////////////////////////////////////

  // Lowest address maps to the most significant lane
  always_comb begin
    case (word_size_i)
      SIZE_BYTE: sel_dec = 4'b1000 >> addr_i[1:0];
      SIZE_HALF: sel_dec = addr_i[1] ? 4'b0011 : 4'b1100;
      SIZE_WORD: sel_dec = 4'b1111;
      default:   sel_dec = 4'b1111;
    endcase
  end

  // Move short data into its lanes, zero elsewhere
  always_comb begin
    case (sel_dec)
      4'b1000: wdat_dec = {top_byte, 24'h0};
      4'b0100: wdat_dec = {8'h0, top_byte, 16'h0};
      4'b0010: wdat_dec = {16'h0, top_byte, 8'h0};
      4'b0001: wdat_dec = {24'h0, top_byte};
      4'b1100: wdat_dec = {top_half, 16'h0};
      4'b0011: wdat_dec = {16'h0, top_half};
      default: wdat_dec = data_i;
    endcase
  end

  //////////////////////////////////////////////////
  // Request latch and handshake
  //////////////////////////////////////////////////

  // Ready drops on acceptance and returns with the done pulse
  // Start toggle flips once per accepted request
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rdy_q     <= 1'b1;
      str_tgl_q <= 1'b0;
      we_q      <= 1'b0;
    end else if (accept) begin
      rdy_q     <= 1'b0;
      str_tgl_q <= ~str_tgl_q;
      we_q      <= ~rd_wrn_i;
    end else if (done_p_i) begin
      rdy_q     <= 1'b1;
    end
  end

  // Payload only moves on acceptance
  always_ff @(posedge tck_i) begin
    if (accept) begin
      sel_q  <= sel_dec;
      adr_q  <= addr_i;
      wdat_q <= wdat_dec;
    end
  end

  assign rdy_o     = rdy_q;
  assign str_tgl_o = str_tgl_q;
  assign sel_o     = sel_q;
  assign adr_o     = adr_q;
  assign wdat_o    = wdat_q;
  assign we_o      = we_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // A start toggle only follows a strobe seen while ready
  a_tgl_on_accept: assert property (
    @(posedge tck_i) disable iff (rst_i)
    $changed(str_tgl_q) |-> $past(strobe_i && rdy_q)
  ) else $error("str_tgl_o flipped without an accepted strobe");

endmodule

// ==== source/dbg_toggle_sync.sv ====
// Carries a toggle across a clock boundary and turns each flip into a single pulse
// One instance per direction between the TCK and Wishbone domains

`timescale 1ns/10ps

module dbg_toggle_sync (
  input  logic clk_i,
  input  logic rst_i,
  // Toggle from the source domain
  input  logic tgl_i,
  // One destination cycle per flip
  output logic pulse_o
);

  //////////////////////////////////////////////////
  // Resynchronizer
  //////////////////////////////////////////////////

  // First stage may go metastable
  logic meta_q;

  // Settled copy of the toggle
  logic sync_q;

  // Previous settled value, for edge detect
  logic prev_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      meta_q <= 1'b0;
      sync_q <= 1'b0;
      prev_q <= 1'b0;
    end else begin
      meta_q <= tgl_i;
      sync_q <= meta_q;
      prev_q <= sync_q;
    end
  end

  //////////////////////////////////////////////////
  // Toggle detect
  //////////////////////////////////////////////////

  // Either direction of the flip counts
  // Pulse shows two to three edges after the source flip
  assign pulse_o = sync_q ^ prev_q;

endmodule

// ==== source/dbg_wb_biu.sv ====
// Top level of the debug bus interface unit, TCK-side requests to single Wishbone cycles
// Connects command capture, the two toggle synchronizers and the Wishbone master

`timescale 1ns/10ps

module dbg_wb_biu (
  // Debug side, TCK domain
  input  logic                          tck_i,
  input  logic                          rst_i,
  input  logic [dbg_biu_pkg::ADDR_W-1:0] addr_i,
  input  logic [dbg_biu_pkg::DATA_W-1:0] data_i,
  input  logic                          rd_wrn_i,
  input  logic [dbg_biu_pkg::SIZE_W-1:0] word_size_i,
  input  logic                          strobe_i,
  output logic                          rdy_o,
  output logic [dbg_biu_pkg::DATA_W-1:0] data_o,
  output logic                          err_o,
  // Wishbone side
  input  logic                          wb_clk_i,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [dbg_biu_pkg::ADDR_W-1:0] wb_adr_o,
  output logic [dbg_biu_pkg::SEL_W-1:0]  wb_sel_o,
  output logic [dbg_biu_pkg::DATA_W-1:0] wb_dat_o,
  input  logic [dbg_biu_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_err_i
);

  import dbg_biu_pkg::*;

  //////////////////////////////////////////////////
  // Cross-domain wiring
  //////////////////////////////////////////////////

  // Request held in TCK flops, sampled only inside the Wishbone cycle
  logic [SEL_W-1:0]  sel_q;
  logic [ADDR_W-1:0] adr_q;
  logic [DATA_W-1:0] wdat_q;
  logic              we_q;

  // Toggles and their resynchronized pulses
  logic              str_tgl;
  logic              start_p;
  logic              rdy_tgl;
  logic              done_p;

  dbg_cmd_capture u_capture (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .addr_i      (addr_i),
    .data_i      (data_i),
    .rd_wrn_i    (rd_wrn_i),
    .word_size_i (word_size_i),
    .strobe_i    (strobe_i),
    .done_p_i    (done_p),
    .rdy_o       (rdy_o),
    .str_tgl_o   (str_tgl),
    .sel_o       (sel_q),
    .adr_o       (adr_q),
    .wdat_o      (wdat_q),
    .we_o        (we_q)
  );

  // TCK to Wishbone start
  dbg_toggle_sync u_start_sync (
    .clk_i   (wb_clk_i),
    .rst_i   (rst_i),
    .tgl_i   (str_tgl),
    .pulse_o (start_p)
  );

  // Wishbone to TCK completion
  dbg_toggle_sync u_done_sync (
    .clk_i   (tck_i),
    .rst_i   (rst_i),
    .tgl_i   (rdy_tgl),
    .pulse_o (done_p)
  );

  // data_o and err_o settle well before done_p reaches TCK
  dbg_wb_master u_master (
    .wb_clk_i  (wb_clk_i),
    .rst_i     (rst_i),
    .start_p_i (start_p),
    .sel_i     (sel_q),
    .adr_i     (adr_q),
    .wdat_i    (wdat_q),
    .we_i      (we_q),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_i  (wb_ack_i),
    .wb_err_i  (wb_err_i),
    .wb_cyc_o  (wb_cyc_o),
    .wb_stb_o  (wb_stb_o),
    .wb_we_o   (wb_we_o),
    .wb_adr_o  (wb_adr_o),
    .wb_sel_o  (wb_sel_o),
    .wb_dat_o  (wb_dat_o),
    .rdat_o    (data_o),
    .err_o     (err_o),
    .rdy_tgl_o (rdy_tgl)
  );

endmodule

// ==== source/dbg_wb_master.sv ====
// Wishbone-side stage of the debug bus unit, runs one classic single cycle per start pulse
// Returns right-justified read data, the error flag and a completion toggle

`timescale 1ns/10ps

module dbg_wb_master (
  input  logic                          wb_clk_i,
  input  logic                          rst_i,
  // Start pulse, already in the Wishbone domain
  input  logic                          start_p_i,
  // Request held by the TCK side
  input  logic [dbg_biu_pkg::SEL_W-1:0]  sel_i,
  input  logic [dbg_biu_pkg::ADDR_W-1:0] adr_i,
  input  logic [dbg_biu_pkg::DATA_W-1:0] wdat_i,
  input  logic                          we_i,
  // Wishbone master port
  input  logic [dbg_biu_pkg::DATA_W-1:0] wb_dat_i,
  input  logic                          wb_ack_i,
  input  logic                          wb_err_i,
  output logic                          wb_cyc_o,
  output logic                          wb_stb_o,
  output logic                          wb_we_o,
  output logic [dbg_biu_pkg::ADDR_W-1:0] wb_adr_o,
  output logic [dbg_biu_pkg::SEL_W-1:0]  wb_sel_o,
  output logic [dbg_biu_pkg::DATA_W-1:0] wb_dat_o,
  // Result back to the TCK side
  output logic [dbg_biu_pkg::DATA_W-1:0] rdat_o,
  output logic                          err_o,
  output logic                          rdy_tgl_o
);

  import dbg_biu_pkg::*;

  //////////////////////////////////////////////////
  // Declarations
  //////////////////////////////////////////////////

  wb_state_e         state_q;
  wb_state_e         state_d;

  // FSM outputs
  logic              cyc_c;
  logic              stb_c;
  logic              done_c;

  // Result registers
  logic [DATA_W-1:0] rdat_q;
  logic              err_q;
  logic              rdy_tgl_q;

  // Selected read lanes, right-justified
  logic [DATA_W-1:0] rdat_dec;

  //////////////////////////////////////////////////
  // Cycle FSM
  //////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= WB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Cycle opens in the start cycle itself
  // A zero-wait answer never leaves idle
  always_comb begin
    state_d = state_q;
    cyc_c   = 1'b0;
    stb_c   = 1'b0;
    done_c  = 1'b0;
    case (state_q)
      WB_IDLE: begin
        if (start_p_i) begin
          cyc_c = 1'b1;
          stb_c = 1'b1;
          if (wb_ack_i || wb_err_i) begin
            done_c = 1'b1;
          end else begin
            state_d = WB_XFER;
          end
        end
      end
      WB_XFER: begin
        cyc_c = 1'b1;
        stb_c = 1'b1;
        if (wb_ack_i || wb_err_i) begin
          done_c  = 1'b1;
          state_d = WB_IDLE;
        end
      end
      default: state_d = WB_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Read lane extract and result registers
  //////////////////////////////////////////////////

  // Lanes come back right-justified with zero upper bits
  always_comb begin
    case (sel_i)
      4'b1100: rdat_dec = {16'h0, wb_dat_i[31:16]};
      4'b0011: rdat_dec = {16'h0, wb_dat_i[15:0]};
      4'b1000: rdat_dec = {24'h0, wb_dat_i[31:24]};
      4'b0100: rdat_dec = {24'h0, wb_dat_i[23:16]};
      4'b0010: rdat_dec = {24'h0, wb_dat_i[15:8]};
      4'b0001: rdat_dec = {24'h0, wb_dat_i[7:0]};
      default: rdat_dec = wb_dat_i;
    endcase
  end

  // Read data only on a clean read ack, old value kept on error
  always_ff @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      rdat_q    <= '0;
      err_q     <= 1'b0;
      rdy_tgl_q <= 1'b0;
    end else if (done_c) begin
      if (wb_ack_i && !wb_err_i && !we_i) begin
        rdat_q <= rdat_dec;
      end
      err_q     <= wb_err_i;
      rdy_tgl_q <= ~rdy_tgl_q;
    end
  end

  assign wb_cyc_o  = cyc_c;
  assign wb_stb_o  = stb_c;
  assign wb_we_o   = we_i;
  assign wb_adr_o  = adr_i;
  assign wb_sel_o  = sel_i;
  assign wb_dat_o  = wdat_i;
  assign rdat_o    = rdat_q;
  assign err_o     = err_q;
  assign rdy_tgl_o = rdy_tgl_q;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Classic single cycles keep strobe and cycle together
  a_stb_is_cyc: assert property (
    @(posedge wb_clk_i) disable iff (rst_i)
    wb_stb_o == wb_cyc_o
  ) else $error("wb_stb_o differs from wb_cyc_o");

  // TCK side must wait for ready before the next start
  a_no_start_in_xfer: assert property (
    @(posedge wb_clk_i) disable iff (rst_i)
    (state_q == WB_XFER) |-> !start_p_i
  ) else $error("start_p_i arrived during a cycle");

  // Held request may not move while the slave waits
  a_req_stable: assert property (
    @(posedge wb_clk_i) disable iff (rst_i)
    (wb_cyc_o && !(wb_ack_i || wb_err_i)) |=>
      $stable({wb_adr_o, wb_sel_o, wb_dat_o, wb_we_o})
  ) else $error("Wishbone request changed during wait states");

endmodule

// ==== src.f ====
source/dbg_biu_pkg.sv
source/dbg_cmd_capture.sv
source/dbg_toggle_sync.sv
source/dbg_wb_master.sv
source/dbg_wb_biu.sv
verification/dbg_wb_slave_model.sv
verification/tb_dbg_wb_biu.sv

// ==== verification/dbg_wb_slave_model.sv ====
// Wishbone memory model for the debug bus unit testbench
// Random wait states per cycle, error answer at one fixed address

`timescale 1ns/10ps

module dbg_wb_slave_model #(
  parameter logic [dbg_biu_pkg::ADDR_W-1:0] ERR_ADR = 32'h0000_003c
) (
  input  logic                          wb_clk_i,
  input  logic                          rst_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [dbg_biu_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [dbg_biu_pkg::SEL_W-1:0]  wb_sel_i,
  input  logic [dbg_biu_pkg::DATA_W-1:0] wb_dat_i,
  output logic [dbg_biu_pkg::DATA_W-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          wb_err_o
);

  import dbg_biu_pkg::*;

  // 16 words, indexed by address bits 5 to 2
  logic [DATA_W-1:0] mem [0:15];

  // Wait states of the current cycle and the count so far
  logic [1:0]        wait_len;
  logic [1:0]        wait_cnt;
  logic              answer;
  logic              bad_adr;
  integer            seed;

  initial begin
    seed = 32'hb065a9fd;
    // Fill pattern spans the whole byte address
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h5a00_0000 ^ ((i * 4) * 32'h0001_0203);
    end
  end

  // Answer comes combinationally once the wait states are used up
  assign bad_adr  = wb_adr_i[ADDR_W-1:2] == ERR_ADR[ADDR_W-1:2];
  assign answer   = wb_cyc_i && wb_stb_i && (wait_cnt == wait_len);
  assign wb_ack_o = answer && !bad_adr;
  assign wb_err_o = answer && bad_adr;
  assign wb_dat_o = mem[wb_adr_i[5:2]];

  // New wait length drawn after each answer, writes honour the lanes
  always @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      wait_cnt <= 2'd0;
      wait_len <= 2'd0;
    end else if (answer) begin
      wait_cnt <= 2'd0;
      wait_len <= 2'($random(seed));
      if (wb_ack_o && wb_we_i) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (wb_sel_i[i]) begin
            mem[wb_adr_i[5:2]][8*i +: 8] <= wb_dat_i[8*i +: 8];
          end
        end
      end
    end else if (wb_cyc_i && wb_stb_i) begin
      wait_cnt <= wait_cnt + 2'd1;
    end
  end

endmodule

// ==== verification/tb_dbg_wb_biu.sv ====
// Testbench for the debug bus interface unit that drives the TCK side and checks with assertions
// A Wishbone memory model with random wait states answers the cycles

`timescale 1ns/10ps

module tb_dbg_wb_biu;

  import dbg_biu_pkg::*;

  // Word 15 answers with wb_err_i
  localparam logic [ADDR_W-1:0] ERR_ADR     = 32'h0000_003c;
  // 40 transactions of at most 60 Wishbone cycles
  localparam int                TIMEOUT_CYC = 40 * 60;

  logic              tck_i;
  logic              wb_clk_i;
  logic              rst_i;
  logic [ADDR_W-1:0] addr_i;
  logic [DATA_W-1:0] data_i;
  logic              rd_wrn_i;
  logic [SIZE_W-1:0] word_size_i;
  logic              strobe_i;
  logic              rdy_o;
  logic [DATA_W-1:0] data_o;
  logic              err_o;
  logic              wb_cyc_o;
  logic              wb_stb_o;
  logic              wb_we_o;
  logic [ADDR_W-1:0] wb_adr_o;
  logic [SEL_W-1:0]  wb_sel_o;
  logic [DATA_W-1:0] wb_dat_o;
  logic [DATA_W-1:0] wb_dat_i;
  logic              wb_ack_i;
  logic              wb_err_i;

  // Expected values of the request in flight
  logic [SEL_W-1:0]  exp_sel;
  logic [ADDR_W-1:0] exp_adr;
  logic              exp_we;
  logic [DATA_W-1:0] exp_wdat;
  logic [DATA_W-1:0] exp_data;
  logic              exp_err;

  // Shadow of the slave memory and the last good read
  logic [DATA_W-1:0] shadow [0:15];
  logic [DATA_W-1:0] last_data;
  int                errors;
  int                reqs;
  int                cycles_done;
  int                wb_cycles;

  dbg_wb_biu UUT (.*);

  dbg_wb_slave_model #(.ERR_ADR(ERR_ADR)) u_slave (
    .wb_clk_i (wb_clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_o),
    .wb_stb_i (wb_stb_o),
    .wb_we_i  (wb_we_o),
    .wb_adr_i (wb_adr_o),
    .wb_sel_i (wb_sel_o),
    .wb_dat_i (wb_dat_o),
    .wb_dat_o (wb_dat_i),
    .wb_ack_o (wb_ack_i),
    .wb_err_o (wb_err_i)
  );

  //////////////////////////////////////////////////
  // Clocks and timeout
  //////////////////////////////////////////////////

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  initial begin
    tck_i = 1'b0;
    forever #50 tck_i = ~tck_i;
  end

  initial begin
    wb_cycles = 0;
    while (wb_cycles < TIMEOUT_CYC) begin
      @(posedge wb_clk_i);
      wb_cycles++;
    end
    $display("Timeout after %0d Wishbone cycles, a request never completed", wb_cycles);
    $display("Some tests failed");
    $finish;
  end

  // One completed Wishbone cycle per accepted request
  always @(posedge wb_clk_i or posedge rst_i) begin
    if (rst_i) begin
      cycles_done <= 0;
    end else if (wb_cyc_o && (wb_ack_i || wb_err_i)) begin
      cycles_done <= cycles_done + 1;
    end
  end

  //////////////////////////////////////////////////
  // Big-endian lane and placement rules
  //////////////////////////////////////////////////

  // Bit offset of the lowest selected lane
  function automatic int lane_shift(input logic [SIZE_W-1:0] size, input logic [1:0] off);
    case (size)
      SIZE_BYTE: lane_shift = 8 * (3 - off);
      SIZE_HALF: lane_shift = off[1] ? 0 : 16;
      default:   lane_shift = 0;
    endcase
  endfunction

  function automatic logic [3:0] lane_mask(input logic [SIZE_W-1:0] size, input int sh);
    case (size)
      SIZE_BYTE: lane_mask = 4'b0001 << (sh / 8);
      SIZE_HALF: lane_mask = 4'b0011 << (sh / 8);
      default:   lane_mask = 4'b1111;
    endcase
  endfunction

  // Short write data taken from the top of the debug word
  function automatic logic [31:0] top_piece(input logic [SIZE_W-1:0] size, input logic [31:0] d);
    case (size)
      SIZE_BYTE: top_piece = {24'h0, d[31:24]};
      SIZE_HALF: top_piece = {16'h0, d[31:16]};
      default:   top_piece = d;
    endcase
  endfunction

  function automatic logic [31:0] lane_bits(input logic [3:0] sel);
    lane_bits = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
    errors++;
  endtask

  task automatic report_fault(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_sel: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_stb_o |-> wb_sel_o == exp_sel)
    else report_mismatch("wb_sel_o", $sampled(exp_sel), $sampled(wb_sel_o));
  a_adr: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_stb_o |-> wb_adr_o == exp_adr)
    else report_mismatch("wb_adr_o", $sampled(exp_adr), $sampled(wb_adr_o));
  a_we: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_stb_o |-> wb_we_o == exp_we)
    else report_mismatch("wb_we_o", $sampled(exp_we), $sampled(wb_we_o));
  a_wdat: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (wb_stb_o && wb_we_o) |-> wb_dat_o == exp_wdat)
    else report_mismatch("wb_dat_o", $sampled(exp_wdat), $sampled(wb_dat_o));

  // Cycle held through wait states while ready stays low
  a_hold: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    (wb_cyc_o && !wb_ack_i && !wb_err_i) |=> (wb_cyc_o && wb_stb_o))
    else report_fault("wb_cyc_o or wb_stb_o dropped before the slave answered");
  a_busy: assert property (@(posedge wb_clk_i) disable iff (rst_i)
    wb_cyc_o |-> !rdy_o)
    else report_mismatch("rdy_o", 0, $sampled(rdy_o));

  // Results seen on the edge after rdy_o rises
  a_data: assert property (@(posedge tck_i) disable iff (rst_i)
    $rose(rdy_o) |-> data_o == exp_data)
    else report_mismatch("data_o", $sampled(exp_data), $sampled(data_o));
  a_err: assert property (@(posedge tck_i) disable iff (rst_i)
    $rose(rdy_o) |-> err_o == exp_err)
    else report_mismatch("err_o", $sampled(exp_err), $sampled(err_o));
  a_count: assert property (@(posedge tck_i) disable iff (rst_i)
    $rose(rdy_o) |-> cycles_done == reqs)
    else report_mismatch("cycles_done", $sampled(reqs), $sampled(cycles_done));

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Starts on a falling tck_i edge and returns after the result check
  task automatic run_req(input logic [31:0] adr, input logic [31:0] dat, input logic rd,
                         input logic [SIZE_W-1:0] size, input logic busy_strobe);
    int         sh;
    logic [3:0] sel;
    logic       bad;
    sh  = lane_shift(size, adr[1:0]);
    sel = lane_mask(size, sh);
    bad = adr[31:2] == ERR_ADR[31:2];
    while (rdy_o !== 1'b1) @(negedge tck_i);
    exp_sel  = sel;
    exp_adr  = adr;
    exp_we   = !rd;
    exp_err  = bad;
    exp_wdat = top_piece(size, dat) << sh;
    // Errored cycles leave memory and read data alone
    if (!rd && !bad) begin
      shadow[adr[5:2]] = (shadow[adr[5:2]] & ~lane_bits(sel)) | exp_wdat;
    end
    if (rd && !bad) begin
      last_data = (shadow[adr[5:2]] & lane_bits(sel)) >> sh;
    end
    exp_data    = last_data;
    addr_i      = adr;
    data_i      = dat;
    rd_wrn_i    = rd;
    word_size_i = size;
    strobe_i    = 1'b1;
    reqs++;
    @(negedge tck_i);
    strobe_i = 1'b0;
    // Extra strobes while rdy_o is low start nothing
    if (busy_strobe) begin
      addr_i   = adr ^ 32'h20;
      strobe_i = 1'b1;
      repeat (2) @(negedge tck_i);
      strobe_i = 1'b0;
    end
    while (rdy_o !== 1'b1) @(negedge tck_i);
    @(negedge tck_i);
  endtask

  initial begin
    errors      = 0;
    reqs        = 0;
    last_data   = '0;
    exp_sel     = '0;
    exp_adr     = '0;
    exp_we      = 1'b0;
    exp_wdat    = '0;
    exp_data    = '0;
    exp_err     = 1'b0;
    rst_i       = 1'b1;
    addr_i      = '0;
    data_i      = '0;
    rd_wrn_i    = 1'b1;
    word_size_i = SIZE_WORD;
    strobe_i    = 1'b0;
    repeat (4) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    rst_i = 1'b0;

    // Idle outputs out of reset
    assert (rdy_o === 1'b1) else report_mismatch("rdy_o", 1, rdy_o);
    assert (wb_cyc_o === 1'b0) else report_mismatch("wb_cyc_o", 0, wb_cyc_o);
    assert (err_o === 1'b0) else report_mismatch("err_o", 0, err_o);
    assert (data_o === '0) else report_mismatch("data_o", 0, data_o);
    @(negedge tck_i);

    // Word write and read back
    run_req(32'h04, 32'h1234_5678, 1'b0, SIZE_WORD, 1'b0);
    run_req(32'h04, 32'h0, 1'b1, SIZE_WORD, 1'b0);

    // Byte writes at every offset with junk in the low bits of the debug word
    run_req(32'h10, 32'ha1b2_c3d4, 1'b0, SIZE_WORD, 1'b0);
    for (int off = 0; off < 4; off++) begin
      run_req(32'h10 + off, {8'(17 * (off + 1)), 24'hff_ffff}, 1'b0, SIZE_BYTE, 1'b0);
      run_req(32'h10, 32'h0, 1'b1, SIZE_WORD, 1'b0);
    end

    // Halfword writes at both offsets
    run_req(32'h14, 32'h0bad_f00d, 1'b0, SIZE_WORD, 1'b0);
    for (int off = 0; off < 4; off += 2) begin
      run_req(32'h14 + off, {16'(16'h9e37 + off), 16'hffff}, 1'b0, SIZE_HALF, 1'b0);
      run_req(32'h14, 32'h0, 1'b1, SIZE_WORD, 1'b0);
    end

    // Short reads come back right-justified
    for (int off = 0; off < 4; off++) begin
      run_req(32'h04 + off, 32'h0, 1'b1, SIZE_BYTE, 1'b0);
    end
    run_req(32'h04, 32'h0, 1'b1, SIZE_HALF, 1'b0);
    run_req(32'h06, 32'h0, 1'b1, SIZE_HALF, 1'b0);

    // Error address followed by a good access that clears err_o
    run_req(ERR_ADR, 32'h0, 1'b1, SIZE_WORD, 1'b0);
    run_req(32'h10, 32'h0, 1'b1, SIZE_HALF, 1'b0);
    run_req(ERR_ADR, 32'hdead_beef, 1'b0, SIZE_WORD, 1'b0);
    run_req(32'h14, 32'h0, 1'b1, SIZE_WORD, 1'b0);

    // Unknown size code runs as a word
    run_req(32'h18, 32'h7654_3210, 1'b0, 3'd7, 1'b0);
    run_req(32'h18, 32'h0, 1'b1, SIZE_WORD, 1'b0);

    // Strobes while busy
    run_req(32'h14, 32'h0, 1'b1, SIZE_WORD, 1'b1);

    $display("Requests %0d, Wishbone cycles %0d, errors %0d", reqs, cycles_done, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
